/* hdl/f8_alu.sv */
module f8_alu (
	input f8_pkg::alu_op_t op,
	input f8_pkg::byte_t left,
	input f8_pkg::byte_t right,
	input logic c_in,
	output f8_pkg::byte_t result,
	output f8_pkg::flags_t alu_flags
);
	f8_pkg::byte_t add_a;
	f8_pkg::byte_t add_b;
	logic add_ci;
	logic [f8_pkg::data_w:0] sum;

	// adder operands. for the other ops the adder just passes left, so c and ov stay 0.
	always_comb begin
		add_a = left;
		add_b = '0;
		add_ci = 1'b0;
		case (op)
			f8_pkg::alu_add: add_b = right;
			f8_pkg::alu_link: add_ci = c_in;
			f8_pkg::alu_inc: add_ci = 1'b1;
			f8_pkg::alu_cmp: begin
				add_a = right;	// right minus left.
				add_b = ~left;
				add_ci = 1'b1;
			end
			f8_pkg::alu_dec_r: begin
				add_a = right;
				add_b = '1;
			end
			default: ;
		endcase
	end

	assign sum = {1'b0, add_a} + {1'b0, add_b} + {{f8_pkg::data_w{1'b0}}, add_ci};

	always_comb begin
		assert #0 (!$isunknown(op)) else $error("f8_alu: unknown op");
		case (op)
			f8_pkg::alu_l: result = left;
			f8_pkg::alu_r: result = right;
			f8_pkg::alu_and: result = left & right;
			f8_pkg::alu_or: result = left | right;
			f8_pkg::alu_xor: result = left ^ right;
			f8_pkg::alu_com: result = ~left;
			f8_pkg::alu_sl1: result = {left[6:0], 1'b0};
			f8_pkg::alu_sl4: result = {left[3:0], 4'h0};
			f8_pkg::alu_sr1: result = {1'b0, left[7:1]};
			f8_pkg::alu_sr4: result = {4'h0, left[7:4]};
			default: result = sum[f8_pkg::data_w-1:0];
		endcase
	end

	assign alu_flags.s = ~result[7];	// s means positive.
	assign alu_flags.z = (result == '0);
	assign alu_flags.c = sum[f8_pkg::data_w];
	assign alu_flags.ov = (add_a[7] == add_b[7]) && (sum[7] != add_a[7]);
endmodule

/* hdl/f8_cpu.sv */
module f8_cpu (
	input logic clk,
	input logic rst_re,
	input f8_pkg::byte_t db_in,
	input f8_pkg::byte_t io0_in,
	input f8_pkg::byte_t io1_in,
	output f8_pkg::romc_t romc,
	output logic write,
	output f8_pkg::byte_t io0_out,
	output f8_pkg::byte_t io1_out
);
	f8_pkg::byte_t opcode;
	logic [2:0] step;
	logic [2:0] step_next;
	logic last_clk;
	logic last_step;
	logic long_cycle;
	f8_pkg::romc_t romc_next;
	f8_pkg::alu_op_t alu_op;
	f8_pkg::lbus_sel_t lbus_sel;
	f8_pkg::rbus_sel_t rbus_sel;
	logic acc_we;
	logic isar_we;
	f8_pkg::addr_t isar_d;
	f8_pkg::addr_t isar;
	f8_pkg::flags_t flags;
	f8_pkg::flags_t flags_next;
	f8_pkg::flags_t alu_flags;
	f8_pkg::addr_t scr_raddr;
	f8_pkg::addr_t scr_waddr;
	logic scr_we;
	f8_pkg::byte_t scr_rdata;
	logic [1:0] io_we;
	logic [1:0] io_re;
	f8_pkg::byte_t left;
	f8_pkg::byte_t right;
	f8_pkg::byte_t result;
	logic c_in;

	assign write = last_clk;

	f8_sequencer seq_i (
		.clk(clk),
		.rst_re(rst_re),
		.db_in(db_in),
		.romc_next(romc_next),
		.long_cycle(long_cycle),
		.last_step(last_step),
		.step_next(step_next),
		.opcode(opcode),
		.step(step),
		.romc(romc),
		.last_clk(last_clk)
	);

	f8_decode dec_i (
		.opcode(opcode),
		.step(step),
		.isar(isar),
		.flags(flags),
		.alu_flags(alu_flags),
		.result(result),
		.romc_next(romc_next),
		.long_cycle(long_cycle),
		.last_step(last_step),
		.step_next(step_next),
		.alu_op(alu_op),
		.lbus_sel(lbus_sel),
		.rbus_sel(rbus_sel),
		.acc_we(acc_we),
		.isar_we(isar_we),
		.isar_d(isar_d),
		.flags_next(flags_next),
		.scr_raddr(scr_raddr),
		.scr_waddr(scr_waddr),
		.scr_we(scr_we),
		.io_we(io_we),
		.io_re(io_re)
	);

	f8_datapath dp_i (
		.clk(clk),
		.rst_re(rst_re),
		.last_clk(last_clk),
		.db_in(db_in),
		.io0_in(io0_in),
		.io1_in(io1_in),
		.scr_rdata(scr_rdata),
		.result(result),
		.alu_op(alu_op),
		.lbus_sel(lbus_sel),
		.rbus_sel(rbus_sel),
		.acc_we(acc_we),
		.isar_we(isar_we),
		.isar_d(isar_d),
		.flags_next(flags_next),
		.io_we(io_we),
		.io_re(io_re),
		.left(left),
		.right(right),
		.c_in(c_in),
		.isar(isar),
		.flags(flags),
		.io0_out(io0_out),
		.io1_out(io1_out)
	);

	f8_alu alu_i (
		.op(alu_op),
		.left(left),
		.right(right),
		.c_in(c_in),
		.result(result),
		.alu_flags(alu_flags)
	);

	f8_scratchpad scr_i (
		.clk(clk),
		.raddr(scr_raddr),
		.rdata(scr_rdata),
		.waddr(scr_waddr),
		.wdata(result),
		.we(scr_we && last_clk)
	);
endmodule

/* hdl/f8_datapath.sv */
module f8_datapath (
	input logic clk,
	input logic rst_re,
	input logic last_clk,
	input f8_pkg::byte_t db_in,
	input f8_pkg::byte_t io0_in,
	input f8_pkg::byte_t io1_in,
	input f8_pkg::byte_t scr_rdata,
	input f8_pkg::byte_t result,
	input f8_pkg::alu_op_t alu_op,
	input f8_pkg::lbus_sel_t lbus_sel,
	input f8_pkg::rbus_sel_t rbus_sel,
	input logic acc_we,
	input logic isar_we,
	input f8_pkg::addr_t isar_d,
	input f8_pkg::flags_t flags_next,
	input logic [1:0] io_we,
	input logic [1:0] io_re,
	output f8_pkg::byte_t left,
	output f8_pkg::byte_t right,
	output logic c_in,
	output f8_pkg::addr_t isar,
	output f8_pkg::flags_t flags,
	output f8_pkg::byte_t io0_out,
	output f8_pkg::byte_t io1_out
);
	localparam int pad_w = f8_pkg::data_w - f8_pkg::addr_w;

	f8_pkg::byte_t acc;
	f8_pkg::byte_t idata;

	always_ff @(posedge clk) begin
		if (!rst_re) begin
			acc <= '0;
			isar <= '0;
			flags <= '0;
			io0_out <= '0;
			io1_out <= '0;
		end else if (last_clk) begin
			if (acc_we) acc <= result;
			if (isar_we) isar <= isar_d;
			flags <= flags_next;	// decode holds them when unchanged.
			if (io_we[0]) io0_out <= result;
			if (io_we[1]) io1_out <= result;
		end
	end

	always_comb begin
		if (io_re[0]) idata = io0_in;
		else if (io_re[1]) idata = io1_in;
		else idata = db_in;
	end

	always_comb begin
		case (lbus_sel)
			f8_pkg::lbus_acc: left = acc;
			f8_pkg::lbus_status: left = {4'h0, flags};
			f8_pkg::lbus_const_f: left = 8'h0f;
			default: left = 8'h00;
		endcase
		case (rbus_sel)
			f8_pkg::rbus_scr: right = scr_rdata;
			f8_pkg::rbus_isar: right = {{pad_w{1'b0}}, isar};
			f8_pkg::rbus_inst: right = {{pad_w{1'b0}}, isar_d};	// opcode field from decode.
			default: right = idata;
		endcase
	end

	assign c_in = flags.c && (alu_op == f8_pkg::alu_link);

	assert property (@(posedge clk) disable iff (!rst_re) !(io_we[0] && io_we[1]));
endmodule

/* hdl/f8_decode.sv */
module f8_decode (
	input f8_pkg::byte_t opcode,
	input logic [2:0] step,
	input f8_pkg::addr_t isar,
	input f8_pkg::flags_t flags,
	input f8_pkg::flags_t alu_flags,
	input f8_pkg::byte_t result,
	output f8_pkg::romc_t romc_next,
	output logic long_cycle,
	output logic last_step,
	output logic [2:0] step_next,
	output f8_pkg::alu_op_t alu_op,
	output f8_pkg::lbus_sel_t lbus_sel,
	output f8_pkg::rbus_sel_t rbus_sel,
	output logic acc_we,
	output logic isar_we,
	output f8_pkg::addr_t isar_d,
	output f8_pkg::flags_t flags_next,
	output f8_pkg::addr_t scr_raddr,
	output f8_pkg::addr_t scr_waddr,
	output logic scr_we,
	output logic [1:0] io_we,
	output logic [1:0] io_re
);
	f8_pkg::addr_t ind_addr;
	f8_pkg::addr_t ind_isar;
	logic ind_step;
	logic ind_use;
	logic force_long;
	f8_pkg::flags_t logic_flags;

	// logic ops, shifts and com clear c and ov.
	assign logic_flags = '{ov: 1'b0, z: alu_flags.z, c: 1'b0, s: alu_flags.s};

	assign long_cycle = force_long ||
		!(romc_next inside {f8_pkg::romc_fetch, 5'h0d, f8_pkg::romc_io, 5'h1d});

	// register field of the scratchpad opcodes.
	always_comb begin
		ind_addr = isar;
		ind_isar = isar;
		ind_step = 1'b0;
		case (opcode[3:0])
			f8_pkg::isar_plain: ind_addr = isar;
			f8_pkg::isar_inc: begin
				ind_step = 1'b1;
				ind_isar = {isar[5:3], isar[2:0] + 3'd1};	// low octal digit wraps.
			end
			f8_pkg::isar_dec: begin
				ind_step = 1'b1;
				ind_isar = {isar[5:3], isar[2:0] - 3'd1};
			end
			default: begin
				if (opcode[3:0] <= f8_pkg::isar_direct_max) ind_addr = f8_pkg::addr_t'(opcode[3:0]);
			end
		endcase
	end

	always_comb begin
		romc_next = f8_pkg::romc_fetch;
		force_long = 1'b0;
		last_step = 1'b1;
		step_next = step + 3'd1;
		alu_op = f8_pkg::alu_l;
		lbus_sel = f8_pkg::lbus_acc;
		rbus_sel = f8_pkg::rbus_scr;
		acc_we = 1'b0;
		isar_we = 1'b0;
		isar_d = opcode[5:0];	// also the inst source of the right bus.
		flags_next = flags;
		scr_raddr = ind_addr;
		scr_waddr = ind_addr;
		scr_we = 1'b0;
		io_we = 2'b00;
		io_re = 2'b00;
		ind_use = 1'b0;

		case (opcode) inside
			f8_pkg::op_lr_a_is: begin
				rbus_sel = f8_pkg::rbus_isar;
				alu_op = f8_pkg::alu_r;
				acc_we = 1'b1;
			end
			f8_pkg::op_lr_is_a: begin
				isar_we = 1'b1;
				isar_d = result[5:0];
			end
			f8_pkg::op_sr1, f8_pkg::op_sr4, f8_pkg::op_sl1, f8_pkg::op_sl4, f8_pkg::op_com: begin
				acc_we = 1'b1;
				flags_next = logic_flags;
				case (opcode)
					f8_pkg::op_sr1: alu_op = f8_pkg::alu_sr1;
					f8_pkg::op_sr4: alu_op = f8_pkg::alu_sr4;
					f8_pkg::op_sl1: alu_op = f8_pkg::alu_sl1;
					f8_pkg::op_sl4: alu_op = f8_pkg::alu_sl4;
					default: alu_op = f8_pkg::alu_com;
				endcase
			end
			f8_pkg::op_lnk, f8_pkg::op_inc: begin
				acc_we = 1'b1;
				flags_next = alu_flags;
				alu_op = (opcode == f8_pkg::op_lnk) ? f8_pkg::alu_link : f8_pkg::alu_inc;
			end
			f8_pkg::op_lr_w_j: begin
				scr_raddr = f8_pkg::reg_j;
				alu_op = f8_pkg::alu_r;
				flags_next = f8_pkg::flags_t'(result[3:0]);
			end
			f8_pkg::op_lr_j_w: begin
				lbus_sel = f8_pkg::lbus_status;
				scr_waddr = f8_pkg::reg_j;
				scr_we = 1'b1;
			end
			f8_pkg::op_li, f8_pkg::op_ni, f8_pkg::op_oi, f8_pkg::op_xi, f8_pkg::op_ai,
			f8_pkg::op_ci: begin
				// operand cycle, then the default fetch cycle.
				if (step == 3'd0) begin
					romc_next = f8_pkg::romc_imm;
					last_step = 1'b0;
					rbus_sel = f8_pkg::rbus_idata;
					acc_we = (opcode != f8_pkg::op_ci);
					case (opcode)
						f8_pkg::op_li: alu_op = f8_pkg::alu_r;
						f8_pkg::op_ni: alu_op = f8_pkg::alu_and;
						f8_pkg::op_oi: alu_op = f8_pkg::alu_or;
						f8_pkg::op_xi: alu_op = f8_pkg::alu_xor;
						f8_pkg::op_ai: alu_op = f8_pkg::alu_add;
						default: alu_op = f8_pkg::alu_cmp;
					endcase
					if (opcode inside {f8_pkg::op_ai, f8_pkg::op_ci}) flags_next = alu_flags;
					else if (opcode != f8_pkg::op_li) flags_next = logic_flags;
				end
			end
			f8_pkg::op_nop: ;
			[f8_pkg::op_ds : f8_pkg::op_ds | 8'h0f]: begin
				force_long = 1'b1;
				ind_use = 1'b1;
				alu_op = f8_pkg::alu_dec_r;
				scr_we = 1'b1;
				flags_next = alu_flags;
			end
			[f8_pkg::op_lr_a_r : f8_pkg::op_lr_a_r | 8'h0f]: begin
				ind_use = 1'b1;
				alu_op = f8_pkg::alu_r;
				acc_we = 1'b1;
			end
			[f8_pkg::op_lr_r_a : f8_pkg::op_lr_r_a | 8'h0f]: begin
				ind_use = 1'b1;
				scr_we = 1'b1;
			end
			[f8_pkg::op_lisu : f8_pkg::op_lisu | 8'h07]: begin
				isar_we = 1'b1;
				isar_d = {opcode[2:0], isar[2:0]};
			end
			[f8_pkg::op_lisl : f8_pkg::op_lisl | 8'h07]: begin
				isar_we = 1'b1;
				isar_d = {isar[5:3], opcode[2:0]};
			end
			[f8_pkg::op_lis : f8_pkg::op_lis | 8'h0f]: begin
				lbus_sel = f8_pkg::lbus_const_f;
				rbus_sel = f8_pkg::rbus_inst;
				alu_op = f8_pkg::alu_and;
				acc_we = 1'b1;
			end
			[f8_pkg::op_ins : f8_pkg::op_outs | 8'h0f]: begin
				if (step == 3'd0) begin
					romc_next = f8_pkg::romc_io;
					last_step = 1'b0;
					if (opcode[3:1] == 3'd0) begin
						if (opcode[4]) begin
							io_we[opcode[0]] = 1'b1;	// outs.
						end else begin
							io_re[opcode[0]] = 1'b1;
							rbus_sel = f8_pkg::rbus_idata;
							alu_op = f8_pkg::alu_r;
							acc_we = 1'b1;
							flags_next = logic_flags;
						end
					end
				end
			end
			[f8_pkg::op_as : f8_pkg::op_as | 8'h0f], [f8_pkg::op_xs : f8_pkg::op_ns | 8'h0f]: begin
				ind_use = 1'b1;
				acc_we = 1'b1;
				if (opcode[7:4] == f8_pkg::op_as[7:4]) begin
					alu_op = f8_pkg::alu_add;
					flags_next = alu_flags;
				end else begin
					alu_op = opcode[4] ? f8_pkg::alu_and : f8_pkg::alu_xor;
					flags_next = logic_flags;
				end
			end
			default: ;	// dropped opcodes behave as nop.
		endcase

		if (ind_use && ind_step) begin
			isar_we = 1'b1;
			isar_d = ind_isar;
		end
	end
endmodule

/* hdl/f8_pkg.sv */
package f8_pkg;
	localparam int data_w = 8;
	localparam int addr_w = 6;
	localparam int romc_w = 5;

	typedef logic [data_w-1:0] byte_t;
	typedef logic [addr_w-1:0] addr_t;
	typedef logic [romc_w-1:0] romc_t;

	// same layout as the low status nibble, s in bit 0.
	typedef struct packed {
		logic ov;
		logic z;
		logic c;
		logic s;
	} flags_t;

	typedef enum logic [3:0] {
		alu_l, alu_r, alu_and, alu_or, alu_xor, alu_add, alu_link, alu_inc,
		alu_cmp, alu_com, alu_sl1, alu_sl4, alu_sr1, alu_sr4, alu_dec_r
	} alu_op_t;

	typedef enum logic [1:0] {lbus_acc, lbus_status, lbus_const_f, lbus_const_0} lbus_sel_t;
	typedef enum logic [1:0] {rbus_scr, rbus_isar, rbus_inst, rbus_idata} rbus_sel_t;

	localparam romc_t romc_fetch = 5'h00;
	localparam romc_t romc_imm = 5'h03;
	localparam romc_t romc_io = 5'h1c;	// short port cycle of ins/outs.

	localparam int short_cycle_clocks = 4;
	localparam int long_cycle_clocks = 6;

	localparam addr_t reg_j = 6'd9;

	// low nibble of scratchpad opcodes.
	localparam logic [3:0] isar_direct_max = 4'hb;
	localparam logic [3:0] isar_plain = 4'hc;
	localparam logic [3:0] isar_inc = 4'hd;
	localparam logic [3:0] isar_dec = 4'he;

	localparam byte_t op_lr_a_is = 8'h0a;
	localparam byte_t op_lr_is_a = 8'h0b;
	localparam byte_t op_sr1 = 8'h12;
	localparam byte_t op_sl1 = 8'h13;
	localparam byte_t op_sr4 = 8'h14;
	localparam byte_t op_sl4 = 8'h15;
	localparam byte_t op_com = 8'h18;
	localparam byte_t op_lnk = 8'h19;
	localparam byte_t op_lr_w_j = 8'h1d;
	localparam byte_t op_lr_j_w = 8'h1e;
	localparam byte_t op_inc = 8'h1f;
	localparam byte_t op_li = 8'h20;
	localparam byte_t op_ni = 8'h21;
	localparam byte_t op_oi = 8'h22;
	localparam byte_t op_xi = 8'h23;
	localparam byte_t op_ai = 8'h24;
	localparam byte_t op_ci = 8'h25;
	localparam byte_t op_nop = 8'h2b;
	// group opcodes, the low nibble carries a register or port.
	localparam byte_t op_ds = 8'h30;
	localparam byte_t op_lr_a_r = 8'h40;
	localparam byte_t op_lr_r_a = 8'h50;
	localparam byte_t op_lisu = 8'h60;
	localparam byte_t op_lisl = 8'h68;
	localparam byte_t op_lis = 8'h70;
	localparam byte_t op_ins = 8'ha0;
	localparam byte_t op_outs = 8'hb0;
	localparam byte_t op_as = 8'hc0;
	localparam byte_t op_xs = 8'he0;
	localparam byte_t op_ns = 8'hf0;
endpackage

/* hdl/f8_scratchpad.sv */
module f8_scratchpad (
	input logic clk,
	input f8_pkg::addr_t raddr,
	output f8_pkg::byte_t rdata,
	input f8_pkg::addr_t waddr,
	input f8_pkg::byte_t wdata,
	input logic we
);
	f8_pkg::byte_t mem [2**f8_pkg::addr_w];

	// read is combinational so the alu sees the register in the same cycle.
	assign rdata = mem[raddr];

	// we is only high on the last clock of a machine cycle.
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end
endmodule

/* hdl/f8_sequencer.sv */
module f8_sequencer (
	input logic clk,
	input logic rst_re,
	input f8_pkg::byte_t db_in,
	input f8_pkg::romc_t romc_next,
	input logic long_cycle,
	input logic last_step,
	input logic [2:0] step_next,
	output f8_pkg::byte_t opcode,
	output logic [2:0] step,
	output f8_pkg::romc_t romc,
	output logic last_clk
);
	logic [2:0] clk_in_cycle;

	assign last_clk = long_cycle ?
		(clk_in_cycle == 3'(f8_pkg::long_cycle_clocks - 1)) :
		(clk_in_cycle == 3'(f8_pkg::short_cycle_clocks - 1));

	always_ff @(posedge clk) begin
		if (!rst_re) begin
			clk_in_cycle <= '0;
			step <= '0;
			opcode <= f8_pkg::op_nop;	// first cycle is a plain fetch.
			romc <= f8_pkg::romc_fetch;
		end else begin
			clk_in_cycle <= last_clk ? 3'd0 : clk_in_cycle + 3'd1;
			if (last_clk) begin
				step <= last_step ? 3'd0 : step_next;
				if (last_step) opcode <= db_in;
			end
			// decode has the new opcode and step during clock 0.
			if (clk_in_cycle == 3'd0) romc <= romc_next;
		end
	end

	// the cycle length holds once a cycle has begun.
	assert property (@(posedge clk) disable iff (!rst_re)
		(clk_in_cycle != 3'd0) |-> $stable(long_cycle));
	// romc shows the code that decode gives for this cycle.
	assert property (@(posedge clk) disable iff (!rst_re)
		(clk_in_cycle != 3'd0) |-> (romc == romc_next));
endmodule

/* project.f */
+incdir+tb
hdl/f8_pkg.sv
hdl/f8_alu.sv
hdl/f8_scratchpad.sv
hdl/f8_sequencer.sv
hdl/f8_decode.sv
hdl/f8_datapath.sv
hdl/f8_cpu.sv
tb/f8_tb.sv

/* run.sh */
#!/bin/sh
# builds the f8 core testbench with Verilator and runs it; the exit status is the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module f8_tb -o f8_sim \
	&& ./obj_dir/f8_sim \
	|| exit 1

/* tb/f8_ref.svh */
`ifndef F8_REF_SVH
`define F8_REF_SVH

function automatic f8_pkg::byte_t rnd();
	return f8_pkg::byte_t'($urandom);
endfunction

function automatic f8_pkg::flags_t logic_flags(input f8_pkg::byte_t r);
	f8_pkg::flags_t f;
	f.s = ~r[7];
	f.z = (r == 8'h00);
	f.c = 1'b0;
	f.ov = 1'b0;
	return f;
endfunction

// 8-bit add with carry in and the full set of add flags.
function automatic void add8(input f8_pkg::byte_t x, input f8_pkg::byte_t y, input logic ci,
	output f8_pkg::byte_t r, output f8_pkg::flags_t f);
	logic [8:0] s9;
	s9 = {1'b0, x} + {1'b0, y} + {8'h00, ci};
	r = s9[7:0];
	f.s = ~r[7];
	f.z = (r == 8'h00);
	f.c = s9[8];
	f.ov = (x[7] == y[7]) && (r[7] != x[7]);
endfunction

// instruction-level model that records both ports after each outs.
function automatic void ref_run(input f8_pkg::byte_t p[$], input f8_pkg::byte_t in0,
	input f8_pkg::byte_t in1, output f8_pkg::byte_t q0[$], output f8_pkg::byte_t q1[$]);
	f8_pkg::byte_t a;
	f8_pkg::byte_t op;
	f8_pkg::byte_t v;
	f8_pkg::byte_t r;
	f8_pkg::byte_t p0;
	f8_pkg::byte_t p1;
	f8_pkg::byte_t scr [64];
	f8_pkg::flags_t f;
	f8_pkg::addr_t is;
	f8_pkg::addr_t ra;
	int i;
	a = 8'h00;
	p0 = 8'h00;
	p1 = 8'h00;
	f = '0;
	is = '0;
	i = 0;
	q0 = {};
	q1 = {};
	while (i < p.size()) begin
		op = p[i];
		i++;
		ra = (op[3:0] <= f8_pkg::isar_direct_max) ? f8_pkg::addr_t'(op[3:0]) : is;
		case (op[7:4])
			4'h0: begin
				if (op == f8_pkg::op_lr_a_is) a = {2'b00, is};
				else if (op == f8_pkg::op_lr_is_a) is = a[5:0];
			end
			4'h1: begin
				case (op[3:0])
					4'h2: a = a >> 1;
					4'h3: a = a << 1;
					4'h4: a = a >> 4;
					4'h5: a = a << 4;
					4'h8: a = ~a;
					default: ;
				endcase
				if (op[3:0] inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h8}) f = logic_flags(a);
				else if (op == f8_pkg::op_lnk) add8(a, 8'h00, f.c, a, f);
				else if (op == f8_pkg::op_lr_w_j) f = f8_pkg::flags_t'(scr[9][3:0]);
				else if (op == f8_pkg::op_lr_j_w) scr[9] = {4'h0, f};
				else if (op == f8_pkg::op_inc) add8(a, 8'h00, 1'b1, a, f);
			end
			4'h2: begin
				if (op != f8_pkg::op_nop) begin
					v = p[i];
					i++;
					case (op)
						f8_pkg::op_li: a = v;
						f8_pkg::op_ni: a = a & v;
						f8_pkg::op_oi: a = a | v;
						f8_pkg::op_xi: a = a ^ v;
						f8_pkg::op_ai: add8(a, v, 1'b0, a, f);
						default: add8(v, ~a, 1'b1, r, f);	// ci keeps the accumulator.
					endcase
					if (op inside {f8_pkg::op_ni, f8_pkg::op_oi, f8_pkg::op_xi}) f = logic_flags(a);
				end
			end
			4'h3: add8(scr[ra], 8'hff, 1'b0, scr[ra], f);
			4'h4: a = scr[ra];
			4'h5: scr[ra] = a;
			4'h6: begin
				if (op[3]) is[2:0] = op[2:0];
				else is[5:3] = op[2:0];
			end
			4'h7: a = {4'h0, op[3:0]};
			4'ha: begin
				a = op[0] ? in1 : in0;
				f = logic_flags(a);
			end
			4'hb: begin
				if (op[0]) p1 = a;
				else p0 = a;
				q0.push_back(p0);
				q1.push_back(p1);
			end
			4'hc: add8(a, scr[ra], 1'b0, a, f);
			4'he: begin
				a = a ^ scr[ra];
				f = logic_flags(a);
			end
			4'hf: begin
				a = a & scr[ra];
				f = logic_flags(a);
			end
			default: ;
		endcase
		if (op[7:4] inside {4'h3, 4'h4, 4'h5, 4'hc, 4'he, 4'hf}) begin
			if (op[3:0] == f8_pkg::isar_inc) is[2:0] = is[2:0] + 3'd1;
			else if (op[3:0] == f8_pkg::isar_dec) is[2:0] = is[2:0] - 3'd1;
		end
	end
endfunction

task automatic put(input f8_pkg::byte_t b);
	prog.push_back(b);
endtask

task automatic put_imm(input f8_pkg::byte_t op, input f8_pkg::byte_t v);
	put(op);
	put(v);
endtask

task automatic build_program();
	f8_pkg::byte_t imm_ops [5] = '{f8_pkg::op_li, f8_pkg::op_ni, f8_pkg::op_oi,
		f8_pkg::op_xi, f8_pkg::op_ai};
	f8_pkg::byte_t acc_ops [7] = '{f8_pkg::op_inc, f8_pkg::op_com, f8_pkg::op_lnk,
		f8_pkg::op_sr1, f8_pkg::op_sl1, f8_pkg::op_sr4, f8_pkg::op_sl4};
	repeat (4) put(f8_pkg::op_nop);
	foreach (imm_ops[k]) begin
		put_imm(f8_pkg::op_li, rnd());
		put_imm(imm_ops[k], rnd());
		put(f8_pkg::op_outs);
	end
	foreach (acc_ops[k]) begin
		put_imm(f8_pkg::op_li, rnd());
		put(acc_ops[k]);
		put(f8_pkg::op_outs);
	end
	put(f8_pkg::op_lisu | 8'd3);	// isar = 032 octal.
	put(f8_pkg::op_lisl | 8'd2);
	put_imm(f8_pkg::op_li, rnd());
	put(f8_pkg::op_lr_r_a | 8'(f8_pkg::isar_inc));
	put_imm(f8_pkg::op_li, rnd());
	put(f8_pkg::op_lr_r_a | 8'(f8_pkg::isar_dec));
	put_imm(f8_pkg::op_li, rnd());
	put(f8_pkg::op_lr_r_a | 8'd5);
	put(f8_pkg::op_lr_a_is);
	put(f8_pkg::op_outs | 8'd1);
	put(f8_pkg::op_lr_a_r | 8'(f8_pkg::isar_plain));
	put(f8_pkg::op_outs | 8'd1);
	put(f8_pkg::op_lr_a_r | 8'd5);
	put(f8_pkg::op_as | 8'(f8_pkg::isar_plain));
	put(f8_pkg::op_outs | 8'd1);
	put(f8_pkg::op_xs | 8'd5);
	put(f8_pkg::op_outs | 8'd1);
	put(f8_pkg::op_ns | 8'(f8_pkg::isar_inc));
	put(f8_pkg::op_outs | 8'd1);
	put(f8_pkg::op_lr_a_is);
	put(f8_pkg::op_outs | 8'd1);
	put(f8_pkg::op_lr_a_r | 8'(f8_pkg::isar_plain));	// reads back the decrement store.
	put(f8_pkg::op_outs | 8'd1);
	put_imm(f8_pkg::op_li, 8'h1d);
	put(f8_pkg::op_lr_is_a);
	put(f8_pkg::op_lr_a_is);
	put(f8_pkg::op_outs | 8'd1);
	put(f8_pkg::op_ins);
	put(f8_pkg::op_outs | 8'd1);
	put(f8_pkg::op_ins | 8'd1);
	put(f8_pkg::op_outs);
	for (int k = 0; k < 6; k++) begin
		put_imm(f8_pkg::op_li, (k == 0) ? 8'h80 : rnd());
		case (k % 3)
			0: put_imm(f8_pkg::op_ai, (k == 0) ? 8'h80 : rnd());	// first one overflows.
			1: put_imm(f8_pkg::op_ci, rnd());
			default: begin
				put(f8_pkg::op_lr_r_a | 8'd3);
				put(f8_pkg::op_ds | 8'd3);
			end
		endcase
		put(f8_pkg::op_lr_j_w);
		put(f8_pkg::op_lr_a_r | 8'd9);
		put(f8_pkg::op_outs);
	end
	// carry restored through j feeds lnk, each time against the opposite carry.
	put_imm(f8_pkg::op_li, 8'hff);
	put_imm(f8_pkg::op_ai, 8'h01);	// c is 1 here.
	put_imm(f8_pkg::op_li, 8'h00);
	put(f8_pkg::op_lr_r_a | 8'd9);
	put(f8_pkg::op_lr_w_j);
	put_imm(f8_pkg::op_li, 8'hff);
	put(f8_pkg::op_lnk);
	put(f8_pkg::op_outs);
	put_imm(f8_pkg::op_li, 8'h02);
	put(f8_pkg::op_lr_r_a | 8'd9);
	put(f8_pkg::op_lr_w_j);
	put_imm(f8_pkg::op_li, rnd());
	put(f8_pkg::op_lnk);
	put(f8_pkg::op_outs);
	repeat (4) put(f8_pkg::op_nop);
endtask

`endif

/* tb/f8_tb.sv */
module f8_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk = 1'b0;
	logic rst_re;
	f8_pkg::byte_t db_in;
	f8_pkg::byte_t io0_in;
	f8_pkg::byte_t io1_in;
	f8_pkg::romc_t romc;
	logic write;
	f8_pkg::byte_t io0_out;
	f8_pkg::byte_t io1_out;

	f8_pkg::byte_t prog [$];
	f8_pkg::byte_t exp0 [$];
	f8_pkg::byte_t exp1 [$];
	int rst_cnt = 0;
	int pc = 0;
	bit take = 1'b0;
	int cycles = 0;
	int limit = 0;
	int cnt = 0;
	int fptr = 0;
	int n_out = 0;
	bit port_check = 1'b0;
	bit phase = 1'b0;
	bit first = 1'b1;
	f8_pkg::byte_t exec_op = f8_pkg::op_nop;
	f8_pkg::romc_t exp_romc;
	int exp_len;

	`include "f8_ref.svh"

	f8_cpu dut_i (
		.clk(clk),
		.rst_re(rst_re),
		.db_in(db_in),
		.io0_in(io0_in),
		.io1_in(io1_in),
		.romc(romc),
		.write(write),
		.io0_out(io0_out),
		.io1_out(io1_out)
	);

	always #2 clk = ~clk;

	function automatic f8_pkg::byte_t prog_byte(input int i);
		return (i < prog.size()) ? prog[i] : f8_pkg::op_nop;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input f8_pkg::byte_t got, input f8_pkg::byte_t want);
		if (got !== want) report_failure($sformatf("ERROR %s got %h expected %h", name, got, want));
	endtask

	task automatic check_romc(input f8_pkg::romc_t got, input f8_pkg::romc_t want);
		if (got !== want) report_failure($sformatf("ERROR romc got %h expected %h", got, want));
	endtask

	initial begin
		void'($urandom(32'h63d8));
		rst_re = 1'b0;
		io0_in = rnd();
		io1_in = rnd();
		build_program();
		ref_run(prog, io0_in, io1_in, exp0, exp1);
		limit = prog.size() * 12 + 100;
		db_in = prog_byte(0);
	end

	// pc moves on after a fetch or an immediate cycle.
	always @(negedge clk) begin
		if (!rst_re) begin
			rst_cnt++;
			if (rst_cnt == 8) rst_re <= 1'b1;
		end else begin
			if (take) pc++;
			take = write && (romc == f8_pkg::romc_fetch || romc == f8_pkg::romc_imm);
			db_in = prog_byte(pc);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) report_failure("timeout, the program did not run to its end");
	end

	always @(negedge clk) begin
		if (!rst_re) begin
			cnt = 1;
		end else begin
			if (port_check) begin
				if (n_out >= exp0.size()) begin
					report_failure("more port writes than the program holds");
				end else begin
					check_byte("io0_out", io0_out, exp0[n_out]);
					check_byte("io1_out", io1_out, exp1[n_out]);
					n_out++;
					port_check = 1'b0;
				end
			end
			cnt++;
			if (write) begin
				if (first) begin
					check_byte("io0_out", io0_out, 8'h00);
					check_byte("io1_out", io1_out, 8'h00);
					first = 1'b0;
				end
				exp_romc = f8_pkg::romc_fetch;
				if (!phase && exec_op inside {[f8_pkg::op_li : f8_pkg::op_ci]}) begin
					exp_romc = f8_pkg::romc_imm;
				end else if (!phase && exec_op inside {[f8_pkg::op_ins : f8_pkg::op_outs | 8'h0f]}) begin
					exp_romc = f8_pkg::romc_io;
				end
				check_romc(romc, exp_romc);
				exp_len = f8_pkg::short_cycle_clocks;
				if (exp_romc == f8_pkg::romc_imm || (!phase && exec_op[7:4] == f8_pkg::op_ds[7:4]))
					exp_len = f8_pkg::long_cycle_clocks;
				if (cnt != exp_len)
					report_failure($sformatf("machine cycle took %0d clocks instead of %0d", cnt, exp_len));
				cnt = 0;
				if (exp_romc == f8_pkg::romc_io && exec_op[4]) port_check = 1'b1;	// outs.
				if (romc == f8_pkg::romc_fetch && fptr >= prog.size()) begin
					if (n_out == exp0.size()) begin
						$display("RESULT: PASS");
						$finish;
					end else begin
						report_failure("fewer port writes seen than the program holds");
					end
				end else begin
					if (romc == f8_pkg::romc_fetch) begin
						exec_op = prog_byte(fptr);
						phase = 1'b0;
					end else begin
						phase = 1'b1;
					end
					if (romc == f8_pkg::romc_fetch || romc == f8_pkg::romc_imm) fptr++;
				end
			end
		end
	end
endmodule
